// ==== verilog/hl_ctrl_pkg.sv ====
package hl_ctrl_pkg;

  ////////////////////
  // Widths

  localparam int CMD_ADDR_W  = 6;
  localparam int CMD_DATA_W  = 32;
  // PTT, address, clip flag and data word
  localparam int RESP_W      = 40;

  // Top bit of the power-up counter marks the end of counting
  localparam int RESET_CNT_W = 16;

  ////////////////////
  // Power-up thresholds

  // About 410 us at 2.5 MHz
  localparam logic [RESET_CNT_W-1:0] I2C_RST_END   = 16'd1024;
  // About 820 us
  localparam logic [RESET_CNT_W-1:0] I2C_START_END = 16'd2048;
  // About 6.5 ms
  localparam logic [RESET_CNT_W-1:0] CORE_RST_END  = 16'd16384;

  ////////////////////
  // Board identity

  localparam logic [7:0] SERIAL_NO = 8'd60;

  ////////////////////
  // Types

  // Addresses without a name here are echoed back
  typedef enum logic [CMD_ADDR_W-1:0] {
    ADDR_STATUS     = 6'd0,
    ADDR_CLIP_CLEAR = 6'd1
  } cmd_addr_e;

  typedef enum logic [1:0] {
    SEQ_WAIT_ETH,
    SEQ_COUNT,
    SEQ_WAIT_PLL,
    SEQ_RUN
  } seq_state_e;

endpackage

// ==== verilog/cmd_if.sv ====
`timescale 1ns/1ps

// Captured command, handed from the receiver to the IO controller
interface cmd_if;

  // One-cycle request pulse
  logic                                 rqst;
  // Fields below are stable from rqst until the next rqst
  hl_ctrl_pkg::cmd_addr_e               addr;
  logic [hl_ctrl_pkg::CMD_DATA_W-1:0]   data;
  logic                                 ptt;
  logic                                 requires_resp;

  modport source (
    output rqst,
    output addr,
    output data,
    output ptt,
    output requires_resp
  );

  modport sink (
    input rqst,
    input addr,
    input data,
    input ptt,
    input requires_resp
  );

endinterface

// ==== verilog/powerup_sequencer.sv ====
`timescale 1ns/1ps

module powerup_sequencer (
  input  logic clock_2_5MHz,
  input  logic reset_i,
  input  logic ethpll_locked_i,
  input  logic phy_rst_n_i,
  input  logic ad9866pll_locked_i,
  output logic clk_i2c_rst_o,
  output logic clk_i2c_start_o,
  output logic core_rst_o,
  output logic ad9866_rst_n_o
);

  localparam int TOP = hl_ctrl_pkg::RESET_CNT_W - 1;

  logic                              eth_up;
  logic                              count_en;
  logic [hl_ctrl_pkg::RESET_CNT_W-1:0] reset_cnt;
  hl_ctrl_pkg::seq_state_e           state_q;
  hl_ctrl_pkg::seq_state_e           state_d;

  // Network PLL locked and PHY out of reset
  assign eth_up   = ethpll_locked_i & phy_rst_n_i;
  // Pauses without clearing while the network is down
  assign count_en = eth_up & ~reset_cnt[TOP];

  ////////////////////
  // Sequencer FSM

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      hl_ctrl_pkg::SEQ_WAIT_ETH: begin
        if (eth_up) state_d = hl_ctrl_pkg::SEQ_COUNT;
      end
      hl_ctrl_pkg::SEQ_COUNT: begin
        // Straight to run if the converter PLL is already locked
        if (reset_cnt[TOP]) begin
          state_d = ad9866pll_locked_i ? hl_ctrl_pkg::SEQ_RUN : hl_ctrl_pkg::SEQ_WAIT_PLL;
        end
      end
      hl_ctrl_pkg::SEQ_WAIT_PLL: begin
        if (ad9866pll_locked_i) state_d = hl_ctrl_pkg::SEQ_RUN;
      end
      default: state_d = hl_ctrl_pkg::SEQ_RUN;
    endcase
  end

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      state_q   <= hl_ctrl_pkg::SEQ_WAIT_ETH;
      reset_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (count_en) reset_cnt <= reset_cnt + hl_ctrl_pkg::RESET_CNT_W'(1);
    end
  end

  ////////////////////
  // Staged reset levels

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      clk_i2c_rst_o   <= 1'b1;
      clk_i2c_start_o <= 1'b1;
      core_rst_o      <= 1'b1;
      ad9866_rst_n_o  <= 1'b0;
    end else begin
      clk_i2c_rst_o   <= reset_cnt < hl_ctrl_pkg::I2C_RST_END;
      clk_i2c_start_o <= reset_cnt < hl_ctrl_pkg::I2C_START_END;
      core_rst_o      <= reset_cnt < hl_ctrl_pkg::CORE_RST_END;
      // Converter leaves reset once and stays out
      if (state_d == hl_ctrl_pkg::SEQ_RUN) ad9866_rst_n_o <= 1'b1;
    end
  end

  // Converter must never run ahead of the core logic
  a_conv_after_core : assert property (
    @(posedge clock_2_5MHz) disable iff (reset_i)
    ad9866_rst_n_o |-> !core_rst_o
  );

endmodule

// ==== verilog/cmd_receiver.sv ====
`timescale 1ns/1ps

module cmd_receiver (
  input  logic                                clock_2_5MHz,
  input  logic                                reset_i,
  input  logic                                cmd_cnt_i,
  input  logic [hl_ctrl_pkg::CMD_ADDR_W-1:0]  cmd_addr_i,
  input  logic [hl_ctrl_pkg::CMD_DATA_W-1:0]  cmd_data_i,
  input  logic                                cmd_ptt_i,
  input  logic                                cmd_requires_resp_i,
  cmd_if.source                               cmd
);

  logic cnt_meta;
  logic cnt_sync;
  logic cnt_hist;
  logic cnt_changed;

  // Any edge on the synchronized toggle is a new command
  assign cnt_changed = cnt_sync ^ cnt_hist;

  ////////////////////
  // Toggle synchronizer

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      cnt_meta <= 1'b0;
      cnt_sync <= 1'b0;
      cnt_hist <= 1'b0;
      cmd.rqst <= 1'b0;
    end else begin
      cnt_meta <= cmd_cnt_i;
      cnt_sync <= cnt_meta;
      cnt_hist <= cnt_sync;
      cmd.rqst <= cnt_changed;
    end
  end

  ////////////////////
  // Command capture

  // Source holds the fields long enough, so they are sampled directly
  always_ff @(posedge clock_2_5MHz) begin
    if (cnt_changed) begin
      cmd.addr          <= hl_ctrl_pkg::cmd_addr_e'(cmd_addr_i);
      cmd.data          <= cmd_data_i;
      cmd.ptt           <= cmd_ptt_i;
      cmd.requires_resp <= cmd_requires_resp_i;
    end
  end

  // One request per toggle
  a_rqst_single : assert property (
    @(posedge clock_2_5MHz) disable iff (reset_i)
    cmd.rqst |=> !cmd.rqst
  );

endmodule

// ==== verilog/io_controller.sv ====
`timescale 1ns/1ps

module io_controller (
  input  logic                              clock_2_5MHz,
  input  logic                              reset_i,
  input  logic                              core_rst_i,
  cmd_if.sink                               cmd,
  input  logic                              rxclipp_i,
  input  logic                              rxclipn_i,
  input  logic                              thismac_i,
  input  logic                              run_i,
  output logic [hl_ctrl_pkg::RESP_W-1:0]    resp_o,
  output logic                              resp_valid_o,
  output logic                              ptt_o,
  output logic                              led_clip_o
);

  // Status bits in response order: run, thismac, clipn, clipp
  logic [3:0]                         status_meta;
  logic [3:0]                         status_sync;
  logic                               clip_any;
  logic                               clip_sticky;
  logic                               accept;
  logic                               clip_clear;
  logic [hl_ctrl_pkg::CMD_DATA_W-1:0] status_word;
  logic [hl_ctrl_pkg::CMD_DATA_W-1:0] resp_data;

  ////////////////////
  // Status synchronizers

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      status_meta <= '0;
      status_sync <= '0;
    end else begin
      status_meta <= {run_i, thismac_i, rxclipn_i, rxclipp_i};
      status_sync <= status_meta;
    end
  end

  assign clip_any = status_sync[1] | status_sync[0];

  ////////////////////
  // Command decode

  // Nothing is accepted until the core leaves reset
  assign accept     = cmd.rqst & ~core_rst_i;
  assign clip_clear = accept & (cmd.addr == hl_ctrl_pkg::ADDR_CLIP_CLEAR);

  assign status_word = {hl_ctrl_pkg::SERIAL_NO, 20'd0, status_sync};

  always_comb begin
    if (cmd.addr == hl_ctrl_pkg::ADDR_STATUS) begin
      resp_data = status_word;
    end else begin
      resp_data = cmd.data;
    end
  end

  ////////////////////
  // Sticky clip and PTT

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      clip_sticky <= 1'b0;
      ptt_o       <= 1'b0;
    end else begin
      // An active clip input wins over a clear
      if (clip_any) begin
        clip_sticky <= 1'b1;
      end else if (clip_clear) begin
        clip_sticky <= 1'b0;
      end
      if (accept) ptt_o <= cmd.ptt;
    end
  end

  assign led_clip_o = clip_sticky;

  ////////////////////
  // Response

  always_ff @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= accept & cmd.requires_resp;
    end
  end

  // Clip bit reports the flag as it stood before this command
  always_ff @(posedge clock_2_5MHz) begin
    if (accept && cmd.requires_resp) begin
      resp_o <= {cmd.ptt, cmd.addr, clip_sticky, resp_data};
    end
  end

  // Core reset comes from the sequencer, responses must wait for it
  a_no_resp_in_reset : assert property (
    @(posedge clock_2_5MHz) disable iff (reset_i)
    !(resp_valid_o && core_rst_i)
  );

endmodule

// ==== verilog/hl_control.sv ====
`timescale 1ns/1ps

module hl_control (
  input  logic                                clock_2_5MHz,
  input  logic                                reset_i,

  // Power-up
  input  logic                                ethpll_locked_i,
  input  logic                                phy_rst_n_i,
  input  logic                                ad9866pll_locked_i,
  output logic                                clk_i2c_rst_o,
  output logic                                clk_i2c_start_o,
  output logic                                core_rst_o,
  output logic                                ad9866_rst_n_o,

  // Command from the downstream protocol domain
  input  logic                                cmd_cnt_i,
  input  logic [hl_ctrl_pkg::CMD_ADDR_W-1:0]  cmd_addr_i,
  input  logic [hl_ctrl_pkg::CMD_DATA_W-1:0]  cmd_data_i,
  input  logic                                cmd_ptt_i,
  input  logic                                cmd_requires_resp_i,

  // Status levels, asynchronous
  input  logic                                rxclipp_i,
  input  logic                                rxclipn_i,
  input  logic                                thismac_i,
  input  logic                                run_i,

  output logic [hl_ctrl_pkg::RESP_W-1:0]      resp_o,
  output logic                                resp_valid_o,
  output logic                                ptt_o,
  output logic                                led_clip_o
);

  logic core_rst;

  cmd_if cmd_bus ();

  assign core_rst_o = core_rst;

  ////////////////////
  // Reset staging

  powerup_sequencer powerup_sequencer_i (
    .clock_2_5MHz       (clock_2_5MHz),
    .reset_i            (reset_i),
    .ethpll_locked_i    (ethpll_locked_i),
    .phy_rst_n_i        (phy_rst_n_i),
    .ad9866pll_locked_i (ad9866pll_locked_i),
    .clk_i2c_rst_o      (clk_i2c_rst_o),
    .clk_i2c_start_o    (clk_i2c_start_o),
    .core_rst_o         (core_rst),
    .ad9866_rst_n_o     (ad9866_rst_n_o)
  );

  ////////////////////
  // Command path

  cmd_receiver cmd_receiver_i (
    .clock_2_5MHz        (clock_2_5MHz),
    .reset_i             (reset_i),
    .cmd_cnt_i           (cmd_cnt_i),
    .cmd_addr_i          (cmd_addr_i),
    .cmd_data_i          (cmd_data_i),
    .cmd_ptt_i           (cmd_ptt_i),
    .cmd_requires_resp_i (cmd_requires_resp_i),
    .cmd                 (cmd_bus.source)
  );

  io_controller io_controller_i (
    .clock_2_5MHz (clock_2_5MHz),
    .reset_i      (reset_i),
    .core_rst_i   (core_rst),
    .cmd          (cmd_bus.sink),
    .rxclipp_i    (rxclipp_i),
    .rxclipn_i    (rxclipn_i),
    .thismac_i    (thismac_i),
    .run_i        (run_i),
    .resp_o       (resp_o),
    .resp_valid_o (resp_valid_o),
    .ptt_o        (ptt_o),
    .led_clip_o   (led_clip_o)
  );

endmodule

// ==== test/tb_hl_control.sv ====
`timescale 1ns/1ps

module tb_hl_control;

  localparam int SEED = 32'hf5ba6f0a;
  // Covers 32768 power-up cycles and about 40 commands of 10 cycles with margin
  localparam int TIMEOUT_CYCLES = 45000;
  localparam int N_RANDOM_CMDS = 30;

  logic                                clock_2_5MHz;
  logic                                reset_i;
  logic                                ethpll_locked_i;
  logic                                phy_rst_n_i;
  logic                                ad9866pll_locked_i;
  logic                                cmd_cnt_i;
  logic [hl_ctrl_pkg::CMD_ADDR_W-1:0]  cmd_addr_i;
  logic [hl_ctrl_pkg::CMD_DATA_W-1:0]  cmd_data_i;
  logic                                cmd_ptt_i;
  logic                                cmd_requires_resp_i;
  logic                                rxclipp_i;
  logic                                rxclipn_i;
  logic                                thismac_i;
  logic                                run_i;
  logic                                clk_i2c_rst_o;
  logic                                clk_i2c_start_o;
  logic                                core_rst_o;
  logic                                ad9866_rst_n_o;
  logic [hl_ctrl_pkg::RESP_W-1:0]      resp_o;
  logic                                resp_valid_o;
  logic                                ptt_o;
  logic                                led_clip_o;

  // Reference model state
  logic [hl_ctrl_pkg::RESET_CNT_W-1:0] m_cnt;
  logic [2:0]                          exp_stages;
  logic                                exp_conv;
  logic                                cnt_prev;
  logic [2:0]                          cmd_age;
  logic [hl_ctrl_pkg::CMD_ADDR_W-1:0]  m_addr;
  logic [hl_ctrl_pkg::CMD_DATA_W-1:0]  m_data;
  logic                                m_ptt;
  logic                                m_req;
  logic [3:0]                          st_d1;
  logic [3:0]                          st_d2;
  logic                                m_clip;
  logic                                exp_ptt;
  logic                                exp_valid;
  logic [hl_ctrl_pkg::RESP_W-1:0]      exp_resp;
  int                                  cycle_cnt = 0;

  hl_control dut_i (.*);

  initial begin
    clock_2_5MHz = 1'b0;
    forever #100 clock_2_5MHz = ~clock_2_5MHz;
  end

  ////////////////////
  // Reference model

  always @(posedge clock_2_5MHz) begin
    if (reset_i) begin
      m_cnt      <= '0;
      exp_stages <= 3'b111;
      exp_conv   <= 1'b0;
      cnt_prev   <= 1'b0;
      cmd_age    <= '0;
      st_d1      <= '0;
      st_d2      <= '0;
      m_clip     <= 1'b0;
      exp_ptt    <= 1'b0;
      exp_valid  <= 1'b0;
    end else begin
      if (ethpll_locked_i && phy_rst_n_i && !m_cnt[15]) m_cnt <= m_cnt + 16'd1;
      exp_stages <= {m_cnt < hl_ctrl_pkg::I2C_RST_END, m_cnt < hl_ctrl_pkg::I2C_START_END,
                     m_cnt < hl_ctrl_pkg::CORE_RST_END};
      if (m_cnt[15] && ad9866pll_locked_i) exp_conv <= 1'b1;
      // Age of the last toggle in edges
      // The command is accepted on the fourth
      cnt_prev <= cmd_cnt_i;
      cmd_age  <= {cmd_age[1:0], cmd_cnt_i != cnt_prev};
      if (cmd_cnt_i != cnt_prev) begin
        m_addr <= cmd_addr_i;
        m_data <= cmd_data_i;
        m_ptt  <= cmd_ptt_i;
        m_req  <= cmd_requires_resp_i;
      end
      st_d1     <= {run_i, thismac_i, rxclipn_i, rxclipp_i};
      st_d2     <= st_d1;
      exp_valid <= 1'b0;
      if (cmd_age[2] && !exp_stages[0]) begin
        exp_ptt <= m_ptt;
        if (m_req) begin
          exp_valid <= 1'b1;
          exp_resp  <= {m_ptt, m_addr, m_clip, (m_addr == 6'd0) ?
                        {hl_ctrl_pkg::SERIAL_NO, 20'd0, st_d2} : m_data};
        end
      end
      if (st_d2[1] || st_d2[0]) m_clip <= 1'b1;
      else if (cmd_age[2] && !exp_stages[0] && m_addr == 6'd1) m_clip <= 1'b0;
    end
  end

  ////////////////////
  // Checks

  task automatic abort_on_mismatch(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "value check failed");
  endtask

  a_stages : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    {clk_i2c_rst_o, clk_i2c_start_o, core_rst_o} == exp_stages)
    else abort_on_mismatch($sformatf("stage levels %b, expected %b",
      $sampled({clk_i2c_rst_o, clk_i2c_start_o, core_rst_o}), $sampled(exp_stages)));

  a_conv : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    ad9866_rst_n_o == exp_conv)
    else abort_on_mismatch($sformatf("ad9866_rst_n_o is %b, expected %b",
      $sampled(ad9866_rst_n_o), $sampled(exp_conv)));

  a_valid : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    resp_valid_o == exp_valid)
    else abort_on_mismatch($sformatf("resp_valid_o is %b, expected %b",
      $sampled(resp_valid_o), $sampled(exp_valid)));

  a_resp : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    resp_valid_o |-> resp_o == exp_resp)
    else abort_on_mismatch($sformatf("resp_o is %h, expected %h",
      $sampled(resp_o), $sampled(exp_resp)));

  a_ptt : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    ptt_o == exp_ptt)
    else abort_on_mismatch($sformatf("ptt_o is %b, expected %b",
      $sampled(ptt_o), $sampled(exp_ptt)));

  a_clip : assert property (@(posedge clock_2_5MHz) disable iff (reset_i)
    led_clip_o == m_clip)
    else abort_on_mismatch($sformatf("led_clip_o is %b, expected %b",
      $sampled(led_clip_o), $sampled(m_clip)));

  always @(posedge clock_2_5MHz) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  ////////////////////
  // Stimulus

  task automatic hold_cycles(input int n);
    repeat (n) @(negedge clock_2_5MHz);
  endtask

  // Fields settle one cycle before the toggle
  task automatic issue_cmd(input logic [5:0] addr, input logic [31:0] data,
                           input logic ptt, input logic req);
    @(negedge clock_2_5MHz);
    cmd_addr_i          = addr;
    cmd_data_i          = data;
    cmd_ptt_i           = ptt;
    cmd_requires_resp_i = req;
    @(negedge clock_2_5MHz);
    cmd_cnt_i = ~cmd_cnt_i;
  endtask

  task automatic run_cmd(input logic [5:0] addr, input logic [31:0] data,
                         input logic ptt, input logic req);
    issue_cmd(addr, data, ptt, req);
    if (req) begin
      @(negedge clock_2_5MHz);
      while (!resp_valid_o) @(negedge clock_2_5MHz);
      hold_cycles(3);
    end else begin
      hold_cycles(7);
    end
  endtask

  task automatic set_status(input logic [3:0] levels);
    @(negedge clock_2_5MHz);
    {run_i, thismac_i, rxclipn_i, rxclipp_i} = levels;
  endtask

  initial begin
    void'($urandom(SEED));
    reset_i = 1'b1;
    {ethpll_locked_i, phy_rst_n_i, ad9866pll_locked_i} = 3'b000;
    {cmd_cnt_i, cmd_ptt_i, cmd_requires_resp_i} = 3'b000;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    {run_i, thismac_i, rxclipn_i, rxclipp_i} = 4'b0000;
    hold_cycles(8);
    reset_i = 1'b0;

    // Nothing moves while the network side is down
    hold_cycles(20);
    phy_rst_n_i = 1'b1;
    hold_cycles(10);
    ethpll_locked_i = 1'b1;
    hold_cycles(200 + int'($urandom % 700));
    phy_rst_n_i = 1'b0;
    hold_cycles(20 + int'($urandom % 80));
    phy_rst_n_i = 1'b1;

    // Toggle while the core is still held in reset
    hold_cycles(3000);
    issue_cmd(6'd5, $urandom, 1'b1, 1'b1);
    hold_cycles(10);

    while (core_rst_o) @(negedge clock_2_5MHz);
    for (int i = 0; i < N_RANDOM_CMDS; i++) begin
      run_cmd(6'(2 + $urandom % 62), $urandom, 1'($urandom), 1'($urandom));
    end

    // Converter PLL locks late
    while (!m_cnt[15]) @(negedge clock_2_5MHz);
    hold_cycles(5 + int'($urandom % 40));
    ad9866pll_locked_i = 1'b1;
    while (!ad9866_rst_n_o) @(negedge clock_2_5MHz);

    for (int i = 0; i < 4; i++) begin
      set_status(4'($urandom));
      hold_cycles(4);
      run_cmd(hl_ctrl_pkg::ADDR_STATUS, $urandom, 1'($urandom), 1'b1);
    end

    // Sticky clip set by short pulses and cleared by command
    set_status(4'b1100);
    hold_cycles(4);
    run_cmd(hl_ctrl_pkg::ADDR_CLIP_CLEAR, $urandom, 1'b0, 1'b1);
    set_status(4'b1101);
    set_status(4'b1100);
    hold_cycles(4);
    run_cmd(hl_ctrl_pkg::ADDR_CLIP_CLEAR, $urandom, 1'b1, 1'b1);
    set_status(4'b1110);
    set_status(4'b1100);
    hold_cycles(4);
    run_cmd(hl_ctrl_pkg::ADDR_CLIP_CLEAR, $urandom, 1'b0, 1'b1);
    // Clear with the clip input still active
    set_status(4'b1101);
    hold_cycles(4);
    run_cmd(hl_ctrl_pkg::ADDR_CLIP_CLEAR, $urandom, 1'b1, 1'b1);
    set_status(4'b1100);
    hold_cycles(4);
    run_cmd(hl_ctrl_pkg::ADDR_CLIP_CLEAR, $urandom, 1'b0, 1'b1);
    hold_cycles(10);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

// ==== hl_control.f ====
verilog/hl_ctrl_pkg.sv
verilog/cmd_if.sv
verilog/powerup_sequencer.sv
verilog/cmd_receiver.sv
verilog/io_controller.sv
verilog/hl_control.sv
test/tb_hl_control.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -f "$LOG"
{ verilator --binary --timing --assert --top-module tb_hl_control \
    -f hl_control.f -o sim_hl_control &&
  ./obj_dir/sim_hl_control; } 2>&1 | tee "$LOG"
grep -q "TESTS FAILED" "$LOG" && { echo "Simulation failed"; exit 1; }
grep -q "TESTS PASSED" "$LOG" || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"
exit 0
